/* Makefile */
VERILATOR  = verilator
FLAGS      = --binary --timing --assert --timescale 1ns/1ps
LINT_FLAGS = --lint-only -Wall --timing --timescale 1ns/1ps
TOP        = tb_door_lock
FILELIST   = compile.f
OBJ_DIR    = obj_dir
PASS_MSG   = TEST OK

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; echo "$$out"; echo "$$out" | grep -qx "$(PASS_MSG)"

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR)

/* compile.f */
+incdir+hw
hw/door_pkg.sv
hw/panel_pkg.sv
hw/button_debounce.sv
hw/code_checker.sv
hw/door_fsm.sv
hw/lock_display.sv
hw/door_lock_top.sv
tb/door_lock_chk.sv
tb/tb_door_lock.sv

/* hw/button_debounce.sv */
`include "lock_consts.svh"

module button_debounce (
    input  logic clk,
    input  logic rst,
    input  logic botao_interno,
    output logic btn_held,
    output logic btn_release
);

    localparam int CNT_W = $clog2(`DEBOUNCE_TICKS + 1);
    localparam logic [CNT_W-1:0] CNT_MAX = CNT_W'(`DEBOUNCE_TICKS);

    logic [CNT_W-1:0] cnt;     // Cycles the button has been high
    logic             btn_q;   // Button level of the previous cycle

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            cnt         <= '0;
            btn_q       <= 1'b0;
            btn_release <= 1'b0;
        end else begin
            btn_q <= botao_interno;

            // Release counts only after a full-length press
            btn_release <= btn_q && !botao_interno && (cnt == CNT_MAX);

            if (!botao_interno) begin
                cnt <= '0;
            end else if (cnt != CNT_MAX) begin
                cnt <= cnt + 1'b1;   // Saturates at the debounce length
            end
        end
    end

    // Drops in the same cycle that btn_release rises
    assign btn_held = btn_q;

endmodule

/* hw/code_checker.sv */
`include "lock_consts.svh"

module code_checker
    import panel_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  logic  check_start,
    input  code_t digits_value,
    output logic  check_done,
    output logic  check_ok
);

    localparam int IDX_W = $clog2(`NUM_SLOTS);
    localparam logic [IDX_W-1:0] LAST_SLOT = IDX_W'(`NUM_SLOTS - 1);
    localparam code_t EMPTY_CODE = {`CODE_DIGITS{`KEY_EMPTY}};

    code_t            slot_q [`NUM_SLOTS];   // Stored codes
    code_t            code_q;                // Code under test
    logic [IDX_W-1:0] idx;                   // Slot being compared
    logic             busy;
    logic             match;

    // Slots are fixed, loaded at reset
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            slot_q[0] <= `SLOT0_CODE;
            for (int i = 1; i < `NUM_SLOTS; i++) begin
                slot_q[i] <= EMPTY_CODE;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (check_start) begin
            code_q <= digits_value;
        end
    end

    // One slot per cycle, stop at the first hit
    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            busy <= 1'b0;
            idx  <= '0;
        end else if (check_start) begin
            busy <= 1'b1;
            idx  <= '0;
        end else if (busy) begin
            if (check_done) begin
                busy <= 1'b0;
            end else begin
                idx <= idx + 1'b1;
            end
        end
    end

    // An empty slot never matches
    assign match      = (slot_q[idx] != EMPTY_CODE) && (slot_q[idx] == code_q);
    assign check_done = busy && (match || (idx == LAST_SLOT));
    assign check_ok   = busy && match;

endmodule

/* hw/door_fsm.sv */
`include "lock_consts.svh"

module door_fsm
    import door_pkg::*, panel_pkg::*;
(
    input  logic        clk,
    input  logic        rst,
    input  logic        sensor_contato,
    input  logic        digits_valid,
    input  code_t       digits_value,
    input  logic        btn_held,
    input  logic        btn_release,
    input  logic        check_done,
    input  logic        check_ok,
    output logic        check_start,
    output door_state_t state,
    output logic [2:0]  attempts
);

    localparam int TMR_W = 16;

    // Last timer value of each timed state
    localparam logic [TMR_W-1:0] AUTO_LOCK_LAST   = TMR_W'(`AUTO_LOCK_TICKS - 1);
    localparam logic [TMR_W-1:0] BIP_LAST         = TMR_W'(`BIP_TICKS - 1);
    localparam logic [TMR_W-1:0] BLOCK_SHORT_LAST = TMR_W'(`BLOCK_SHORT_TICKS - 1);
    localparam logic [TMR_W-1:0] BLOCK_LONG_LAST  = TMR_W'(`BLOCK_LONG_TICKS - 1);

    door_state_t      state_d;
    key_t             key_class;
    logic [TMR_W-1:0] timer;        // Cycles spent in the current state
    logic [TMR_W-1:0] block_last;

    always_comb begin
        case (digits_value[0])
            `KEY_EMPTY:   key_class = KEY_NONE;
            `KEY_HASH:    key_class = KEY_HASH;
            `KEY_TIMEOUT: key_class = KEY_TIMEOUT;
            default:      key_class = KEY_CODE;
        endcase
    end

    // Long block once the count passes the limit
    assign block_last = (attempts > 3'(`MAX_ATTEMPTS)) ? BLOCK_LONG_LAST : BLOCK_SHORT_LAST;

    always_comb begin
        state_d     = state;
        check_start = 1'b0;
        case (state)
            INIT: begin
                if (!sensor_contato) begin
                    state_d = CLOSED;
                end
            end
            CLOSED: begin
                if (btn_held) begin
                    state_d = UNLOCK_DB;
                end else if (digits_valid) begin
                    case (key_class)
                        KEY_TIMEOUT: state_d = BIP_TIMEOUT;
                        KEY_CODE: begin
                            state_d     = CHECK;
                            check_start = 1'b1;   // Checker latches the code now
                        end
                        default: state_d = CLOSED;  // Empty record or hash key
                    endcase
                end
            end
            CHECK: begin
                if (check_done) begin
                    state_d = check_ok ? AJAR : BLOCKED;
                end
            end
            BLOCKED: begin
                if (timer == block_last) begin
                    state_d = CLOSED;
                end
            end
            AJAR: begin
                if (sensor_contato) begin
                    state_d = OPEN;
                end else if (btn_held) begin
                    state_d = LOCK_DB;
                end else if (timer == AUTO_LOCK_LAST) begin
                    state_d = CLOSED;     // Automatic re-lock
                end
            end
            OPEN: begin
                if (!sensor_contato) begin
                    state_d = AJAR;
                end else if (timer == BIP_LAST) begin
                    state_d = BIP_OPEN;
                end
            end
            UNLOCK_DB: begin
                if (btn_release) begin
                    state_d = AJAR;
                end else if (!btn_held) begin
                    state_d = CLOSED;     // Press too short
                end
            end
            LOCK_DB: begin
                if (btn_release) begin
                    state_d = CLOSED;
                end else if (!btn_held) begin
                    state_d = AJAR;
                end
            end
            BIP_TIMEOUT: state_d = CLOSED;
            BIP_OPEN: begin
                if (!sensor_contato) begin
                    state_d = AJAR;
                end
            end
            default: state_d = INIT;
        endcase
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state    <= INIT;
            timer    <= '0;
            attempts <= '0;
        end else begin
            state <= state_d;

            // Shared timer restarts on every state change
            if (state_d != state) begin
                timer <= '0;
            end else if (timer != '1) begin
                timer <= timer + 1'b1;
            end

            if ((state == CHECK) && check_done) begin
                if (check_ok) begin
                    attempts <= '0;
                end else if (attempts != '1) begin
                    attempts <= attempts + 1'b1;
                end
            end else if ((state == UNLOCK_DB) && btn_release) begin
                attempts <= '0;
            end
        end
    end

endmodule

/* hw/door_lock_top.sv */
module door_lock_top
    import door_pkg::*, panel_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     sensor_contato,
    input  logic     botao_interno,
    input  logic     digits_valid,
    input  code_t    digits_value,
    output bcd_pac_t bcd_pac,
    output logic     teclado_en,
    output logic     display_en,
    output logic     tranca,
    output logic     bip
);

    logic        btn_held;
    logic        btn_release;
    logic        check_start;
    logic        check_done;
    logic        check_ok;
    door_state_t state;
    logic [2:0]  attempts;

    button_debounce u_debounce (
        .clk           (clk),
        .rst           (rst),
        .botao_interno (botao_interno),
        .btn_held      (btn_held),
        .btn_release   (btn_release)
    );

    code_checker u_checker (
        .clk          (clk),
        .rst          (rst),
        .check_start  (check_start),
        .digits_value (digits_value),
        .check_done   (check_done),
        .check_ok     (check_ok)
    );

    door_fsm u_fsm (
        .clk            (clk),
        .rst            (rst),
        .sensor_contato (sensor_contato),
        .digits_valid   (digits_valid),
        .digits_value   (digits_value),
        .btn_held       (btn_held),
        .btn_release    (btn_release),
        .check_done     (check_done),
        .check_ok       (check_ok),
        .check_start    (check_start),
        .state          (state),
        .attempts       (attempts)
    );

    lock_display u_display (
        .state      (state),
        .attempts   (attempts),
        .bcd_pac    (bcd_pac),
        .teclado_en (teclado_en),
        .display_en (display_en),
        .tranca     (tranca),
        .bip        (bip)
    );

endmodule

/* hw/door_pkg.sv */
package door_pkg;

    // Door controller states
    typedef enum logic [4:0] {
        INIT,           // Waits for the door to be shut
        CLOSED,         // Shut and latched
        AJAR,           // Latch released, door still shut
        OPEN,           // Door open
        CHECK,          // Code comparison in progress
        BLOCKED,        // Keypad locked out after a wrong code
        UNLOCK_DB,      // Inside button held while closed
        LOCK_DB,        // Inside button held while ajar
        BIP_TIMEOUT,    // One-cycle beep for a keypad timeout
        BIP_OPEN        // Door left open too long
    } door_state_t;

    // Meaning of the first digit of a keypad record
    typedef enum logic [1:0] {
        KEY_CODE,
        KEY_HASH,
        KEY_TIMEOUT,
        KEY_NONE
    } key_t;

endpackage

/* hw/lock_consts.svh */
`ifndef LOCK_CONSTS_SVH
`define LOCK_CONSTS_SVH

// Code format
`define CODE_DIGITS 20
`define NUM_SLOTS   4

// Special keypad digit values
`define KEY_EMPTY   4'hF
`define KEY_HASH    4'hB
`define KEY_TIMEOUT 4'hE
`define KEY_BAR     4'hA

// Slot 0 holds 1234 in the low digits, padded with empty digits above
`define SLOT0_CODE  {{(`CODE_DIGITS-4){`KEY_EMPTY}}, 4'h1, 4'h2, 4'h3, 4'h4}

// Timer lengths in clock cycles
`define DEBOUNCE_TICKS    4
`define AUTO_LOCK_TICKS   20
`define BIP_TICKS         15
`define BLOCK_SHORT_TICKS 8
`define BLOCK_LONG_TICKS  40

`define MAX_ATTEMPTS      5     // Failures tolerated before the long block

`endif

/* hw/lock_display.sv */
module lock_display
    import door_pkg::*, panel_pkg::*;
(
    input  door_state_t state,
    input  logic [2:0]  attempts,
    output bcd_pac_t    bcd_pac,
    output logic        teclado_en,
    output logic        display_en,
    output logic        tranca,
    output logic        bip
);

    localparam int NUM_DIGITS = 6;

    bcd_t [NUM_DIGITS-1:0] dig;
    disp_code_t            status;

    always_comb begin
        case (state)
            CLOSED:  status = DISP_CLOSED;
            AJAR:    status = DISP_AJAR;
            OPEN:    status = DISP_OPEN;
            default: status = DISP_BLANK;   // INIT and the short-lived states
        endcase
    end

    // One bar per failed attempt while blocked
    always_comb begin
        int bars;
        bars = (attempts > 3'(NUM_DIGITS)) ? NUM_DIGITS : int'(attempts);
        for (int i = 0; i < NUM_DIGITS; i++) begin
            if (state == BLOCKED) begin
                dig[i] = (i < bars) ? DISP_BAR : DISP_BLANK;
            end else begin
                dig[i] = (i == 0) ? status : DISP_BLANK;
            end
        end
    end

    assign bcd_pac    = dig;
    assign display_en = 1'b1;
    assign teclado_en = (state == CLOSED) || (state == OPEN);
    assign tranca     = state inside {CLOSED, CHECK, BLOCKED, UNLOCK_DB, BIP_TIMEOUT};
    assign bip        = (state == BIP_TIMEOUT) || (state == BIP_OPEN);

endmodule

/* hw/panel_pkg.sv */
`include "lock_consts.svh"

package panel_pkg;

    typedef logic [3:0] bcd_t;

    // Digit values shown on the status display
    typedef enum logic [3:0] {
        DISP_INIT   = 4'h0,
        DISP_CLOSED = 4'h1,
        DISP_AJAR   = 4'h2,
        DISP_OPEN   = 4'h3,
        DISP_BAR    = `KEY_BAR,
        DISP_BLANK  = 4'hB
    } disp_code_t;

    typedef struct packed {
        bcd_t bcd5;
        bcd_t bcd4;
        bcd_t bcd3;
        bcd_t bcd2;
        bcd_t bcd1;
        bcd_t bcd0;     // Status digit
    } bcd_pac_t;

    // Digit 0 is the lowest nibble
    typedef bcd_t [`CODE_DIGITS-1:0] code_t;

endpackage

/* tb/door_lock_chk.sv */
module door_lock_chk
    import door_pkg::*;
(
    input logic        clk,
    input logic        rst,
    input door_state_t state,
    input logic        bip,
    input logic        tranca,
    input logic        check_start,
    input logic        check_done
);

    timeunit 1ns;
    timeprecision 100ps;

    int   fail_count = 0;   // Read by the testbench at the end of the run
    logic in_flight;        // A code check is running

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            in_flight <= 1'b0;
        end else if (check_start) begin
            in_flight <= 1'b1;
        end else if (check_done) begin
            in_flight <= 1'b0;
        end
    end

    // Timeout beep is a single cycle
    bip_timeout_pulse: assert property (@(posedge clk) disable iff (rst)
        (bip && state == BIP_TIMEOUT) |=> !(bip && state == BIP_TIMEOUT))
    else begin
        fail_count++;
        $error("bip stayed high in BIP_TIMEOUT for a second cycle");
    end

    no_start_in_flight: assert property (@(posedge clk) disable iff (rst)
        check_start |-> !in_flight)
    else begin
        fail_count++;
        $error("check_start raised while a code check was running");
    end

    closed_is_latched: assert property (@(posedge clk) disable iff (rst)
        (state == CLOSED) |-> tranca)
    else begin
        fail_count++;
        $error("tranca low in CLOSED");
    end

endmodule

/* tb/door_lock_stimulus.txt */
# set <sensor|button> <level>, key <20-digit code, digit 0 rightmost>, wait <cycles>
# expect <tranca> <bip> <bcd_pac, digit 5 leftmost> <max cycles to poll>
expect 1 0 BBBBB1 5
key FFFFFFFFFFFFFFFF1234
expect 0 0 BBBBB2 10
set sensor 1
expect 0 0 BBBBB3 5
set sensor 0
expect 0 0 BBBBB2 5
expect 1 0 BBBBB1 25
key FFFFFFFFFFFFFFFF1235
expect 1 0 BBBBBA 10
expect 1 0 BBBBB1 12
key FFFFFFFFFFFFFFFF1235
expect 1 0 BBBBB1 20
key FFFFFFFFFFFFFFFF1235
expect 1 0 BBBBB1 20
key FFFFFFFFFFFFFFFF1235
expect 1 0 BBBBB1 20
key FFFFFFFFFFFFFFFF1235
expect 1 0 BBBBB1 20
key FFFFFFFFFFFFFFFF1235
expect 1 0 AAAAAA 10
wait 12
expect 1 0 AAAAAA 0
expect 1 0 BBBBB1 40
key FFFFFFFFFFFFFFFF1235
expect 1 0 AAAAAA 10
expect 1 0 BBBBB1 50
set button 1
wait 6
set button 0
expect 0 0 BBBBB2 5
set button 1
wait 6
set button 0
expect 1 0 BBBBB1 5
set button 1
wait 2
set button 0
wait 4
expect 1 0 BBBBB1 0
key FFFFFFFFFFFFFFFF1234
expect 0 0 BBBBB2 10
set sensor 1
expect 0 0 BBBBB3 5
expect 0 1 BBBBBB 20
wait 5
expect 0 1 BBBBBB 0
set sensor 0
expect 0 0 BBBBB2 5
expect 1 0 BBBBB1 25
key FFFFFFFFFFFFFFFFFFFE
expect 1 1 BBBBBB 2
expect 1 0 BBBBB1 3

/* tb/tb_door_lock.sv */
module tb_door_lock
    import panel_pkg::*;
();

    timeunit 1ns;
    timeprecision 100ps;

    localparam int    RESET_CYCLES = 10;
    localparam string STIM_FILE    = "tb/door_lock_stimulus.txt";

    logic     clk;
    logic     rst;
    logic     sensor_contato;
    logic     botao_interno;
    logic     digits_valid;
    code_t    digits_value;
    bcd_pac_t bcd_pac;
    logic     teclado_en;
    logic     display_en;
    logic     tranca;
    logic     bip;

    int checks;
    int mismatches;
    int other_errors;
    int line_no;        // Current record of the stimulus file

    door_lock_top dut_i (
        .clk            (clk),
        .rst            (rst),
        .sensor_contato (sensor_contato),
        .botao_interno  (botao_interno),
        .digits_valid   (digits_valid),
        .digits_value   (digits_value),
        .bcd_pac        (bcd_pac),
        .teclado_en     (teclado_en),
        .display_en     (display_en),
        .tranca         (tranca),
        .bip            (bip)
    );

    bind door_lock_top door_lock_chk chk_i (
        .clk         (clk),
        .rst         (rst),
        .state       (state),
        .bip         (bip),
        .tranca      (tranca),
        .check_start (check_start),
        .check_done  (check_done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Inputs change and outputs are sampled 10 ns after the edge
    task automatic next_cycle();
        @(posedge clk);
        #10;
    endtask

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (exp !== act) begin
            mismatches++;
            $display("MISMATCH %s exp %h act %h (stimulus line %0d)", name, exp, act, line_no);
        end
    endtask

    // Keypad is enabled only when the status digit shows closed or open
    function automatic logic keypad_enabled(input logic [23:0] digits);
        return (digits[3:0] == DISP_CLOSED) || (digits[3:0] == DISP_OPEN);
    endfunction

    task automatic set_input(input string name, input logic value);
        if (name == "sensor") begin
            sensor_contato = value;
        end else if (name == "button") begin
            botao_interno = value;
        end else begin
            other_errors++;
            $display("Unknown input %s in stimulus line %0d", name, line_no);
        end
    endtask

    // One keypad record, valid for a single cycle
    task automatic apply_key(input code_t code);
        digits_value = code;
        digits_valid = 1'b1;
        next_cycle();
        digits_valid = 1'b0;
        digits_value = '1;
    endtask

    task automatic expect_outputs(input logic exp_tranca, input logic exp_bip,
                                  input logic [23:0] exp_digits, input int limit);
        int waited;
        waited = 0;
        while (!(tranca === exp_tranca && bip === exp_bip && bcd_pac === exp_digits)
               && waited < limit) begin
            next_cycle();
            waited++;
        end
        if (limit > 0 && waited == limit &&
            !(tranca === exp_tranca && bip === exp_bip && bcd_pac === exp_digits)) begin
            $display("Outputs did not settle within %0d cycles (stimulus line %0d)",
                     limit, line_no);
        end
        check_value("tranca", 32'(exp_tranca), 32'(tranca));
        check_value("bip", 32'(exp_bip), 32'(bip));
        check_value("bcd_pac", 32'(exp_digits), 32'(bcd_pac));
        check_value("teclado_en", 32'(keypad_enabled(exp_digits)), 32'(teclado_en));
    endtask

    initial begin
        int          fd;
        int          n;
        int          count;
        string       line;
        string       cmd;
        string       name;
        logic [79:0] arg;
        logic        exp_tranca;
        logic        exp_bip;
        logic [23:0] exp_digits;

        checks         = 0;
        mismatches     = 0;
        other_errors   = 0;
        line_no        = 0;
        rst            = 1'b1;
        sensor_contato = 1'b0;
        botao_interno  = 1'b0;
        digits_valid   = 1'b0;
        digits_value   = '1;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            next_cycle();
        end
        // Outputs held in reset
        check_value("tranca", 32'h0, 32'(tranca));
        check_value("bip", 32'h0, 32'(bip));
        check_value("bcd_pac", 32'hBBBBBB, 32'(bcd_pac));
        check_value("teclado_en", 32'h0, 32'(teclado_en));
        check_value("display_en", 32'h1, 32'(display_en));
        rst = 1'b0;

        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            other_errors++;
            $display("Could not open the stimulus file %s", STIM_FILE);
        end else begin
            while ($fgets(line, fd) != 0) begin
                line_no++;
                n = $sscanf(line, "%s", cmd);
                if (n < 1 || cmd.getc(0) == "#") begin
                    continue;       // Blank or comment line
                end
                if (cmd == "set") begin
                    n = $sscanf(line, "%s %s %h", cmd, name, arg);
                    set_input(name, arg[0]);
                end else if (cmd == "key") begin
                    n = $sscanf(line, "%s %h", cmd, arg);
                    apply_key(arg);
                end else if (cmd == "wait") begin
                    n = $sscanf(line, "%s %d", cmd, count);
                    for (int i = 0; i < count; i++) begin
                        next_cycle();
                    end
                end else if (cmd == "expect") begin
                    n = $sscanf(line, "%s %h %h %h %d", cmd, exp_tranca, exp_bip,
                                exp_digits, count);
                    expect_outputs(exp_tranca, exp_bip, exp_digits, count);
                end else begin
                    other_errors++;
                    $display("Unknown command %s in stimulus line %0d", cmd, line_no);
                end
            end
            $fclose(fd);
        end

        next_cycle();   // Let the last assertion sample complete
        $display("Checks %0d, mismatches %0d, other errors %0d, assertion failures %0d",
                 checks, mismatches, other_errors, dut_i.chk_i.fail_count);
        if (mismatches == 0 && other_errors == 0 && dut_i.chk_i.fail_count == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule
